// File: verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data word and pc width
`define CORE_XLEN 32

// general register file
`define CORE_NUM_REGS 32
`define CORE_REG_ADDR_W 5

// event counters wrap at this width
`define CORE_PERF_W 16

`endif

// File: verilog/isa_pkg.sv
`include "core_settings.svh"

package isa_pkg;

  // one data word
  typedef logic [`CORE_XLEN-1:0] word_t;

  // instruction address
  typedef logic [`CORE_XLEN-1:0] pc_t;

  // general register number
  typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

endpackage

// File: verilog/pipe_pkg.sv
`include "core_settings.svh"

package pipe_pkg;

  // issue slot, slot1 is the younger one
  typedef enum logic {
    SLOT0 = 1'b0,
    SLOT1 = 1'b1
  } slot_e;

  // counter select
  typedef enum logic {
    EV_RETIRE   = 1'b0,
    EV_RF_WRITE = 1'b1
  } perf_event_e;

  typedef logic [`CORE_PERF_W-1:0] perf_count_t;

endpackage

// File: verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_es_valid0,
  input  pc_t       i_es_pc0,
  input  logic      i_es_we0,
  input  reg_addr_t i_es_rd0,
  input  word_t     i_es_wdata0,
  input  logic      i_es_valid1,
  input  pc_t       i_es_pc1,
  input  logic      i_es_we1,
  input  reg_addr_t i_es_rd1,
  input  word_t     i_es_wdata1,
  output logic      o_retire0,
  output logic      o_retire1,
  output logic      o_rf_we0,
  output logic      o_rf_we1,
  output reg_addr_t o_rf_waddr0,
  output reg_addr_t o_rf_waddr1,
  output word_t     o_rf_wdata0,
  output word_t     o_rf_wdata1,
  output pc_t       o_wb_pc0,
  output pc_t       o_wb_pc1
);

  logic      valid_q [2];
  logic      we_q    [2];
  pc_t       pc_q    [2];
  reg_addr_t rd_q    [2];
  word_t     wdata_q [2];

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      valid_q[SLOT0] <= 1'b0;
      valid_q[SLOT1] <= 1'b0;
      we_q[SLOT0]    <= 1'b0;
      we_q[SLOT1]    <= 1'b0;
    end else begin
      valid_q[SLOT0] <= i_es_valid0;
      valid_q[SLOT1] <= i_es_valid1;
      we_q[SLOT0]    <= i_es_we0;
      we_q[SLOT1]    <= i_es_we1;
    end
  end

  // payload only loads with a valid slot
  always_ff @(posedge aclk) begin
    if (i_es_valid0) begin
      pc_q[SLOT0]    <= i_es_pc0;
      rd_q[SLOT0]    <= i_es_rd0;
      wdata_q[SLOT0] <= i_es_wdata0;
    end
    if (i_es_valid1) begin
      pc_q[SLOT1]    <= i_es_pc1;
      rd_q[SLOT1]    <= i_es_rd1;
      wdata_q[SLOT1] <= i_es_wdata1;
    end
  end

  assign o_retire0   = valid_q[SLOT0];
  assign o_retire1   = valid_q[SLOT1];
  assign o_rf_we0    = valid_q[SLOT0] & we_q[SLOT0];
  assign o_rf_we1    = valid_q[SLOT1] & we_q[SLOT1];
  assign o_rf_waddr0 = rd_q[SLOT0];
  assign o_rf_waddr1 = rd_q[SLOT1];
  assign o_rf_wdata0 = wdata_q[SLOT0];
  assign o_rf_wdata1 = wdata_q[SLOT1];
  assign o_wb_pc0    = pc_q[SLOT0];
  assign o_wb_pc1    = pc_q[SLOT1];

  // a retiring slot carries known payload
  a_known_after_reset: assert property (@(posedge aclk) disable iff (!i_rst_n)
    !$isunknown({o_retire0, o_retire1, o_rf_we0, o_rf_we1}) and
    (o_retire0 |-> !$isunknown({o_wb_pc0, o_rf_waddr0, o_rf_wdata0})) and
    (o_retire1 |-> !$isunknown({o_wb_pc1, o_rf_waddr1, o_rf_wdata1})));

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regfile import isa_pkg::*; (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_we0,
  input  reg_addr_t i_waddr0,
  input  word_t     i_wdata0,
  input  logic      i_we1,
  input  reg_addr_t i_waddr1,
  input  word_t     i_wdata1,
  input  reg_addr_t i_raddr0,
  input  reg_addr_t i_raddr1,
  input  reg_addr_t i_raddr2,
  input  reg_addr_t i_raddr3,
  output word_t     o_rdata0,
  output word_t     o_rdata1,
  output word_t     o_rdata2,
  output word_t     o_rdata3
);

  word_t regs [`CORE_NUM_REGS];

  // r0 is never written, port 1 is assigned last so it wins
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_we0 && i_waddr0 != '0) begin
        regs[i_waddr0] <= i_wdata0;
      end
      if (i_we1 && i_waddr1 != '0) begin
        regs[i_waddr1] <= i_wdata1;
      end
    end
  end

  // bypass order: younger port, older port, array
  function automatic word_t read_port(input reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (i_we1 && i_waddr1 == addr) begin
      data = i_wdata1;
    end else if (i_we0 && i_waddr0 == addr) begin
      data = i_wdata0;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rdata0 = read_port(i_raddr0);
  end

  always_comb begin
    o_rdata1 = read_port(i_raddr1);
  end

  always_comb begin
    o_rdata2 = read_port(i_raddr2);
  end

  always_comb begin
    o_rdata3 = read_port(i_raddr3);
  end

  a_r0_stays_zero: assert property (@(posedge aclk) disable iff (!i_rst_n)
    regs[0] == '0);

  a_r0_reads_zero: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (i_raddr0 == '0 |-> o_rdata0 == '0) and (i_raddr1 == '0 |-> o_rdata1 == '0) and
    (i_raddr2 == '0 |-> o_rdata2 == '0) and (i_raddr3 == '0 |-> o_rdata3 == '0));

endmodule

// File: verilog/perf_counter.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module perf_counter import isa_pkg::*, pipe_pkg::*; (
  input  logic        aclk,
  input  logic        i_rst_n,
  input  logic        i_retire0,
  input  logic        i_retire1,
  input  logic        i_rf_we0,
  input  logic        i_rf_we1,
  input  perf_event_e i_perf_sel,
  output perf_count_t o_perf_count
);

  logic [1:0]  retire_inc;
  logic [1:0]  write_inc;
  perf_count_t retire_cnt;
  perf_count_t write_cnt;

  // r0 writes count as well
  assign retire_inc = {1'b0, i_retire0} + {1'b0, i_retire1};
  assign write_inc  = {1'b0, i_rf_we0} + {1'b0, i_rf_we1};

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      retire_cnt <= '0;
      write_cnt  <= '0;
    end else begin
      retire_cnt <= retire_cnt + {{(`CORE_PERF_W-2){1'b0}}, retire_inc};
      write_cnt  <= write_cnt + {{(`CORE_PERF_W-2){1'b0}}, write_inc};
    end
  end

  always_comb begin
    case (i_perf_sel)
      EV_RETIRE:   o_perf_count = retire_cnt;
      EV_RF_WRITE: o_perf_count = write_cnt;
      default:     o_perf_count = retire_cnt;
    endcase
  end

  // modulo step between consecutive cycles
  a_step_at_most_two: assert property (@(posedge aclk) disable iff (!i_rst_n)
    $past(i_rst_n) |->
      perf_count_t'(retire_cnt - $past(retire_cnt)) <= perf_count_t'(2) &&
      perf_count_t'(write_cnt - $past(write_cnt)) <= perf_count_t'(2));

endmodule

// File: verilog/core_wb_rf.sv
`timescale 1ns/1ps

module core_wb_rf import isa_pkg::*, pipe_pkg::*; (
  input  logic        aclk,
  input  logic        i_rst_n,
  input  logic        i_es_valid0,
  input  pc_t         i_es_pc0,
  input  logic        i_es_we0,
  input  reg_addr_t   i_es_rd0,
  input  word_t       i_es_wdata0,
  input  logic        i_es_valid1,
  input  pc_t         i_es_pc1,
  input  logic        i_es_we1,
  input  reg_addr_t   i_es_rd1,
  input  word_t       i_es_wdata1,
  input  reg_addr_t   i_raddr0,
  input  reg_addr_t   i_raddr1,
  input  reg_addr_t   i_raddr2,
  input  reg_addr_t   i_raddr3,
  input  perf_event_e i_perf_sel,
  output word_t       o_rdata0,
  output word_t       o_rdata1,
  output word_t       o_rdata2,
  output word_t       o_rdata3,
  output pc_t         o_debug0_wb_pc,
  output logic        o_debug0_wb_rf_wen,
  output reg_addr_t   o_debug0_wb_rf_wnum,
  output word_t       o_debug0_wb_rf_wdata,
  output pc_t         o_debug1_wb_pc,
  output logic        o_debug1_wb_rf_wen,
  output reg_addr_t   o_debug1_wb_rf_wnum,
  output word_t       o_debug1_wb_rf_wdata,
  output perf_count_t o_perf_count
);

  logic retire0;
  logic retire1;

  // debug commit ports come straight from writeback
  wb_stage wb_stage_inst (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_es_valid0 (i_es_valid0),
    .i_es_pc0    (i_es_pc0),
    .i_es_we0    (i_es_we0),
    .i_es_rd0    (i_es_rd0),
    .i_es_wdata0 (i_es_wdata0),
    .i_es_valid1 (i_es_valid1),
    .i_es_pc1    (i_es_pc1),
    .i_es_we1    (i_es_we1),
    .i_es_rd1    (i_es_rd1),
    .i_es_wdata1 (i_es_wdata1),
    .o_retire0   (retire0),
    .o_retire1   (retire1),
    .o_rf_we0    (o_debug0_wb_rf_wen),
    .o_rf_we1    (o_debug1_wb_rf_wen),
    .o_rf_waddr0 (o_debug0_wb_rf_wnum),
    .o_rf_waddr1 (o_debug1_wb_rf_wnum),
    .o_rf_wdata0 (o_debug0_wb_rf_wdata),
    .o_rf_wdata1 (o_debug1_wb_rf_wdata),
    .o_wb_pc0    (o_debug0_wb_pc),
    .o_wb_pc1    (o_debug1_wb_pc)
  );

  regfile regfile_inst (
    .aclk     (aclk),
    .i_rst_n  (i_rst_n),
    .i_we0    (o_debug0_wb_rf_wen),
    .i_waddr0 (o_debug0_wb_rf_wnum),
    .i_wdata0 (o_debug0_wb_rf_wdata),
    .i_we1    (o_debug1_wb_rf_wen),
    .i_waddr1 (o_debug1_wb_rf_wnum),
    .i_wdata1 (o_debug1_wb_rf_wdata),
    .i_raddr0 (i_raddr0),
    .i_raddr1 (i_raddr1),
    .i_raddr2 (i_raddr2),
    .i_raddr3 (i_raddr3),
    .o_rdata0 (o_rdata0),
    .o_rdata1 (o_rdata1),
    .o_rdata2 (o_rdata2),
    .o_rdata3 (o_rdata3)
  );

  perf_counter perf_counter_inst (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_retire0    (retire0),
    .i_retire1    (retire1),
    .i_rf_we0     (o_debug0_wb_rf_wen),
    .i_rf_we1     (o_debug1_wb_rf_wen),
    .i_perf_sel   (i_perf_sel),
    .o_perf_count (o_perf_count)
  );

endmodule

// File: bench/tb_core_wb_rf.sv
`timescale 1ns/1ps

module tb_core_wb_rf import isa_pkg::*, pipe_pkg::*;;

  localparam int CLK_HALF       = 10;
  localparam int RESET_CYCLES   = 10;
  // 10 reset cycles plus about 40 pattern lines, with margin
  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_FIELDS     = 26;
  localparam     PATTERN_FILE   = "bench/wb_rf_patterns.txt";

  logic        aclk;
  logic        i_rst_n;
  logic        i_es_valid0;
  pc_t         i_es_pc0;
  logic        i_es_we0;
  reg_addr_t   i_es_rd0;
  word_t       i_es_wdata0;
  logic        i_es_valid1;
  pc_t         i_es_pc1;
  logic        i_es_we1;
  reg_addr_t   i_es_rd1;
  word_t       i_es_wdata1;
  reg_addr_t   i_raddr0;
  reg_addr_t   i_raddr1;
  reg_addr_t   i_raddr2;
  reg_addr_t   i_raddr3;
  perf_event_e i_perf_sel;
  word_t       o_rdata0;
  word_t       o_rdata1;
  word_t       o_rdata2;
  word_t       o_rdata3;
  pc_t         o_debug0_wb_pc;
  logic        o_debug0_wb_rf_wen;
  reg_addr_t   o_debug0_wb_rf_wnum;
  word_t       o_debug0_wb_rf_wdata;
  pc_t         o_debug1_wb_pc;
  logic        o_debug1_wb_rf_wen;
  reg_addr_t   o_debug1_wb_rf_wnum;
  word_t       o_debug1_wb_rf_wdata;
  perf_count_t o_perf_count;

  logic [31:0] fld [NUM_FIELDS];
  string       line;
  string       test_name;
  int          fd;
  int          n_read;
  int          line_no;
  int          lines_run;
  int          error_count;
  int          cycle_count;
  logic        prev_valid0;
  pc_t         prev_pc0;
  logic        prev_valid1;
  pc_t         prev_pc1;

  core_wb_rf core_wb_rf_inst (
    .aclk                 (aclk),
    .i_rst_n              (i_rst_n),
    .i_es_valid0          (i_es_valid0),
    .i_es_pc0             (i_es_pc0),
    .i_es_we0             (i_es_we0),
    .i_es_rd0             (i_es_rd0),
    .i_es_wdata0          (i_es_wdata0),
    .i_es_valid1          (i_es_valid1),
    .i_es_pc1             (i_es_pc1),
    .i_es_we1             (i_es_we1),
    .i_es_rd1             (i_es_rd1),
    .i_es_wdata1          (i_es_wdata1),
    .i_raddr0             (i_raddr0),
    .i_raddr1             (i_raddr1),
    .i_raddr2             (i_raddr2),
    .i_raddr3             (i_raddr3),
    .i_perf_sel           (i_perf_sel),
    .o_rdata0             (o_rdata0),
    .o_rdata1             (o_rdata1),
    .o_rdata2             (o_rdata2),
    .o_rdata3             (o_rdata3),
    .o_debug0_wb_pc       (o_debug0_wb_pc),
    .o_debug0_wb_rf_wen   (o_debug0_wb_rf_wen),
    .o_debug0_wb_rf_wnum  (o_debug0_wb_rf_wnum),
    .o_debug0_wb_rf_wdata (o_debug0_wb_rf_wdata),
    .o_debug1_wb_pc       (o_debug1_wb_pc),
    .o_debug1_wb_rf_wen   (o_debug1_wb_rf_wen),
    .o_debug1_wb_rf_wnum  (o_debug1_wb_rf_wnum),
    .o_debug1_wb_rf_wdata (o_debug1_wb_rf_wdata),
    .o_perf_count         (o_perf_count)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("Fail %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_pc(input string what, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("Fail %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("Fail %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("Fail %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input perf_count_t exp,
                             input perf_count_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("Fail %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  function automatic bit is_data_line(input string text);
    bit keep;
    keep = 1'b1;
    if (text.len() == 0) begin
      keep = 1'b0;
    end else if (text.getc(0) == "#" || text.getc(0) == "\n" || text.getc(0) == "\r") begin
      keep = 1'b0;
    end
    return keep;
  endfunction

  task automatic set_idle_inputs();
    i_es_valid0 = 1'b0;
    i_es_pc0    = '0;
    i_es_we0    = 1'b0;
    i_es_rd0    = '0;
    i_es_wdata0 = '0;
    i_es_valid1 = 1'b0;
    i_es_pc1    = '0;
    i_es_we1    = 1'b0;
    i_es_rd1    = '0;
    i_es_wdata1 = '0;
    i_raddr0    = '0;
    i_raddr1    = '0;
    i_raddr2    = '0;
    i_raddr3    = '0;
    i_perf_sel  = EV_RETIRE;
  endtask

  task automatic drive_inputs();
    i_es_valid0 = fld[0][0];
    i_es_pc0    = pc_t'(fld[1]);
    i_es_we0    = fld[2][0];
    i_es_rd0    = reg_addr_t'(fld[3]);
    i_es_wdata0 = word_t'(fld[4]);
    i_es_valid1 = fld[5][0];
    i_es_pc1    = pc_t'(fld[6]);
    i_es_we1    = fld[7][0];
    i_es_rd1    = reg_addr_t'(fld[8]);
    i_es_wdata1 = word_t'(fld[9]);
    i_raddr0    = reg_addr_t'(fld[10]);
    i_raddr1    = reg_addr_t'(fld[11]);
    i_raddr2    = reg_addr_t'(fld[12]);
    i_raddr3    = reg_addr_t'(fld[13]);
    i_perf_sel  = perf_event_e'(fld[14][0]);
  endtask

  // slots taken at the coming edge show their pc in the next cycle
  task automatic remember_taken_slots();
    prev_valid0 = fld[0][0];
    prev_pc0    = pc_t'(fld[1]);
    prev_valid1 = fld[5][0];
    prev_pc1    = pc_t'(fld[6]);
  endtask

  // commit number and data only mean something while wen is high
  task automatic check_outputs();
    check_word("rdata0", word_t'(fld[15]), o_rdata0);
    check_word("rdata1", word_t'(fld[16]), o_rdata1);
    check_word("rdata2", word_t'(fld[17]), o_rdata2);
    check_word("rdata3", word_t'(fld[18]), o_rdata3);
    check_bit("debug0 wen", fld[19][0], o_debug0_wb_rf_wen);
    if (fld[19][0]) begin
      check_addr("debug0 wnum", reg_addr_t'(fld[20]), o_debug0_wb_rf_wnum);
      check_word("debug0 wdata", word_t'(fld[21]), o_debug0_wb_rf_wdata);
    end
    if (prev_valid0) begin
      check_pc("debug0 pc", prev_pc0, o_debug0_wb_pc);
    end
    check_bit("debug1 wen", fld[22][0], o_debug1_wb_rf_wen);
    if (fld[22][0]) begin
      check_addr("debug1 wnum", reg_addr_t'(fld[23]), o_debug1_wb_rf_wnum);
      check_word("debug1 wdata", word_t'(fld[24]), o_debug1_wb_rf_wdata);
    end
    if (prev_valid1) begin
      check_pc("debug1 pc", prev_pc1, o_debug1_wb_pc);
    end
    check_count("perf count", perf_count_t'(fld[25]), o_perf_count);
  endtask

  initial begin
    aclk = 1'b0;
    forever #(CLK_HALF) aclk = ~aclk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycle_count++;
    end
    abort_run($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin
    error_count = 0;
    lines_run   = 0;
    line_no     = 0;
    prev_valid0 = 1'b0;
    prev_pc0    = '0;
    prev_valid1 = 1'b0;
    prev_pc1    = '0;
    i_rst_n     = 1'b0;
    set_idle_inputs();
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open pattern file %s", PATTERN_FILE));
    end
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    i_rst_n = 1'b1;
    // one data line per cycle, checked 1 ns before the next rising edge
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (is_data_line(line)) begin
        n_read = $sscanf(line,
          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          test_name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
          fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
          fld[17], fld[18], fld[19], fld[20], fld[21], fld[22], fld[23], fld[24], fld[25]);
        if (n_read != NUM_FIELDS + 1) begin
          abort_run($sformatf("pattern line %0d has %0d fields instead of %0d",
                              line_no, n_read, NUM_FIELDS + 1));
        end
        drive_inputs();
        #(CLK_HALF - 1);
        check_outputs();
        remember_taken_slots();
        lines_run++;
        @(negedge aclk);
      end
    end
    $fclose(fd);
    if (error_count == 0 && lines_run > 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("no pattern lines were run from %s", PATTERN_FILE);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
    end
  end

endmodule

// File: core_wb_rf.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/wb_stage.sv
verilog/regfile.sv
verilog/perf_counter.sv
verilog/core_wb_rf.sv
bench/tb_core_wb_rf.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_wb_rf
FILELIST  ?= core_wb_rf.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/wb_rf_patterns.txt
# name v0 pc0 we0 rd0 wd0 v1 pc1 we1 rd1 wd1 ra0 ra1 ra2 ra3 sel | rdata0..3 | wen0 wnum0 wdata0
# wen1 wnum1 wdata1 | count, all hex, one line per cycle, wnum and wdata matter only with wen
reset_zero 0 0 0 0 0 0 0 0 0 0 1 2 3 4 0 0 0 0 0 0 0 0 0 0 0 0
reset_zero 0 0 0 0 0 0 0 0 0 0 5 6 7 8 1 0 0 0 0 0 0 0 0 0 0 0
bypass_s0 1 100 1 5 11110005 0 0 0 0 0 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
bypass_s0 0 0 0 0 0 0 0 0 0 0 5 5 0 0 0 11110005 11110005 0 0 1 5 11110005 0 0 0 0
bypass_s0 0 0 0 0 0 0 0 0 0 0 5 0 0 0 0 11110005 0 0 0 0 0 0 0 0 0 1
bypass_s0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 1 0 0 0 11110005 0 0 0 0 0 0 1
dual_diff 1 110 1 6 2206 1 114 1 7 3307 6 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
dual_diff 0 0 0 0 0 0 0 0 0 0 6 7 5 0 1 2206 3307 11110005 0 1 6 2206 1 7 3307 1
dual_diff 0 0 0 0 0 0 0 0 0 0 7 6 0 0 0 3307 2206 0 0 0 0 0 0 0 0 3
same_reg 1 120 1 8 a008 1 124 1 8 b008 8 0 0 0 1 0 0 0 0 0 0 0 0 0 0 3
same_reg 0 0 0 0 0 0 0 0 0 0 8 8 8 8 0 b008 b008 b008 b008 1 8 a008 1 8 b008 3
same_reg 0 0 0 0 0 0 0 0 0 0 8 6 7 5 1 b008 2206 3307 11110005 0 0 0 0 0 0 5
r0_write 1 130 1 0 dead0000 1 134 1 0 beef0000 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 5
r0_write 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1 0 0 b008 0 1 0 dead0000 1 0 beef0000 5
r0_write 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 7
r0_write 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7
no_we 1 140 0 5 5500 1 144 0 6 6600 5 6 0 0 0 11110005 2206 0 0 0 0 0 0 0 0 7
no_we 1 148 1 9 9009 0 0 1 5 7700 5 6 0 0 0 11110005 2206 0 0 0 0 0 0 0 0 7
no_we 0 0 0 0 0 0 0 0 0 0 5 6 9 0 0 11110005 2206 9009 0 1 9 9009 0 0 0 9
no_we 0 0 0 0 0 0 0 0 0 0 5 6 9 0 1 11110005 2206 9009 0 0 0 0 0 0 0 8
no_we 0 0 0 0 0 0 0 0 0 0 9 0 0 0 0 9009 0 0 0 0 0 0 0 0 0 a
b2b 1 200 1 a a01 1 204 1 b b01 a b 0 0 0 0 0 0 0 0 0 0 0 0 0 a
b2b 1 208 1 a a02 1 20c 1 c c02 a b c 0 0 a01 b01 0 0 1 a a01 1 b b01 a
b2b 1 210 1 b b03 1 214 1 a a03 a b c 0 1 a02 b01 c02 0 1 a a02 1 c c02 a
b2b 0 0 0 0 0 0 0 0 0 0 a b c d 0 a03 b03 c02 0 1 b b03 1 a a03 e
b2b 0 0 0 0 0 0 0 0 0 0 a b c d 1 a03 b03 c02 0 0 0 0 0 0 0 e
b2b 0 0 0 0 0 0 0 0 0 0 a b c 0 0 a03 b03 c02 0 0 0 0 0 0 0 10
s1_only 0 0 0 0 0 1 300 1 1f ffff001f 1f 0 0 0 1 0 0 0 0 0 0 0 0 0 0 e
s1_only 1 304 1 1f 1234001f 0 0 0 0 0 1f 1f 0 0 0 ffff001f ffff001f 0 0 0 0 0 1 1f ffff001f 10
s1_only 0 0 0 0 0 0 0 0 0 0 1f 0 0 0 1 1234001f 0 0 0 1 1f 1234001f 0 0 0 f
s1_only 0 0 0 0 0 0 0 0 0 0 1f 0 0 0 0 1234001f 0 0 0 0 0 0 0 0 0 12
final 0 0 0 0 0 0 0 0 0 0 1f a 9 8 1 1234001f a03 9009 b008 0 0 0 0 0 0 10
final 0 0 0 0 0 0 0 0 0 0 5 6 7 0 0 11110005 2206 3307 0 0 0 0 0 0 0 12
